/* source/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// Frame delimiters, ASCII "<" and ">"
`define CTRL_SOF 8'h3C
`define CTRL_EOF 8'h3E

// Request destinations
`define CTRL_DEST_WB     8'd1
`define CTRL_DEST_STATUS 8'd2

// Error codes in the payload of a controller reply
`define CTRL_ERR_RESET      8'h00
`define CTRL_ERR_BAD_PACKET 8'hFF
`define CTRL_ERR_BAD_DEST   8'hFE

// Payload lengths
`define CTRL_STATUS_LEN 8'd4
// Type and address bytes counted inside a Wishbone length
`define CTRL_WB_HDR_LEN 8'd3

`define CTRL_WB_ADR_W 16
`define CTRL_DAT_W    8

`endif

/* source/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

	// What the reply writer puts on the wire
	typedef enum logic [1:0] {
		RK_RESET,
		RK_ERROR,
		RK_STATUS,
		RK_WB
	} reply_kind_e;

	// Source byte of an outgoing frame
	typedef enum logic [7:0] {
		SRC_CONTROLLER = 8'd0,
		SRC_WISHBONE   = 8'd1,
		SRC_DBSTATUS   = 8'd2
	} src_id_e;

endpackage

`default_nettype wire

/* source/frame_parser.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module frame_parser (
	input  wire logic       clk_i,
	input  wire logic       reset_i,
	input  wire logic [7:0] dat_i,
	input  wire logic       empty_i,
	output logic            rd_o,
	input  wire logic       status_change_i,
	output logic            status_change_ack_o,
	reply_if.parser         rp,
	wb_cmd_if.parser        wc
);

	typedef enum logic [4:0] {
		P_IDLE, P_SOF, P_DEST, P_ST_PKTNO, P_ST_EOF,
		P_WB_PKTNO, P_WB_LEN, P_WB_TYPE, P_WB_ADRH, P_WB_ADRL,
		P_WB_COUNT, P_WB_EOF, P_WB_START, P_WB_WAIT, P_WB_WEOF,
		P_DRAIN, P_REPLY
	} pstate_e;

	pstate_e state_q;
	pstate_e nxt;
	ctrl_pkg::reply_kind_e kind_q;
	logic [7:0] pktno_q;
	logic [7:0] len_q;
	logic [7:0] last_err;
	logic [7:0] cnt_q;
	logic [15:0] adr_q;
	logic we_q;
	logic bcast_q;
	logic consume;
	logic pop;
	logic is_eof;
	logic fail;
	logic [7:0] fail_code;

	// States that take one byte from the input FIFO
	assign consume = state_q inside {P_SOF, P_DEST, P_ST_PKTNO, P_ST_EOF, P_WB_PKTNO,
		P_WB_LEN, P_WB_TYPE, P_WB_ADRH, P_WB_ADRL, P_WB_COUNT, P_WB_EOF, P_WB_WEOF, P_DRAIN};
	assign pop = consume && !empty_i;
	assign rd_o = pop || wc.take;
	assign is_eof = (dat_i == `CTRL_EOF);

	assign rp.req = (state_q == P_REPLY) && !rp.busy;
	assign rp.kind = kind_q;
	assign rp.pktno = pktno_q;
	assign rp.len = len_q;
	assign rp.err = last_err;
	assign rp.wb_write = we_q;

	// Reads run while the reply streams, writes run before it
	assign wc.start = (state_q == P_WB_START) ||
		(rp.req && kind_q == ctrl_pkg::RK_WB && !we_q);
	assign wc.write = we_q;
	assign wc.adr = adr_q;
	assign wc.count = cnt_q;

	assign status_change_ack_o = rp.req && bcast_q;

	always_comb begin
		nxt = state_q;
		fail = 1'b0;
		fail_code = `CTRL_ERR_BAD_PACKET;
		case (state_q)
			P_IDLE: begin
				if (!rp.busy) begin
					if (status_change_i)
						nxt = P_REPLY;
					else if (!empty_i)
						nxt = P_SOF;
				end
			end
			P_SOF: begin
				if (dat_i != `CTRL_SOF)
					fail = 1'b1;
				else
					nxt = P_DEST;
			end
			P_DEST: begin
				if (dat_i == `CTRL_DEST_WB)
					nxt = P_WB_PKTNO;
				else if (dat_i == `CTRL_DEST_STATUS)
					nxt = P_ST_PKTNO;
				else begin
					fail = 1'b1;
					fail_code = `CTRL_ERR_BAD_DEST;
				end
			end
			P_ST_PKTNO: nxt = P_ST_EOF;
			P_ST_EOF, P_WB_EOF, P_WB_WEOF: begin
				if (!is_eof)
					fail = 1'b1;
				else
					nxt = P_REPLY;
			end
			P_WB_PKTNO: nxt = P_WB_LEN;
			P_WB_LEN: nxt = P_WB_TYPE;
			P_WB_TYPE: nxt = P_WB_ADRH;
			P_WB_ADRH: nxt = P_WB_ADRL;
			P_WB_ADRL: nxt = we_q ? P_WB_START : P_WB_COUNT;
			P_WB_COUNT: nxt = P_WB_EOF;
			P_WB_START: nxt = P_WB_WAIT;
			P_WB_WAIT: begin
				if (wc.done)
					nxt = P_WB_WEOF;
			end
			P_DRAIN: begin
				if (empty_i || is_eof)
					nxt = P_REPLY;
			end
			P_REPLY: begin
				if (!rp.busy)
					nxt = P_IDLE;
			end
			default: nxt = P_IDLE;
		endcase

		// FIFO ran dry in the middle of a packet
		if (consume && empty_i && state_q != P_DRAIN) begin
			fail = 1'b1;
			fail_code = `CTRL_ERR_BAD_PACKET;
		end
		// Skip the rest of a bad packet up to its EOF
		if (fail)
			nxt = (empty_i || is_eof) ? P_REPLY : P_DRAIN;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= P_REPLY;
			kind_q <= ctrl_pkg::RK_RESET;
			pktno_q <= 8'd0;
			len_q <= 8'd1;
			last_err <= `CTRL_ERR_RESET;
			we_q <= 1'b0;
			bcast_q <= 1'b0;
		end else begin
			state_q <= nxt;
			if (state_q == P_SOF)
				bcast_q <= 1'b0;
			if (fail) begin
				kind_q <= ctrl_pkg::RK_ERROR;
				pktno_q <= 8'd0;
				len_q <= 8'd1;
				last_err <= fail_code;
			end else begin
				case (state_q)
					P_IDLE: begin
						if (!rp.busy && status_change_i) begin
							kind_q <= ctrl_pkg::RK_STATUS;
							pktno_q <= 8'd0;
							len_q <= `CTRL_STATUS_LEN;
							bcast_q <= 1'b1;
						end
					end
					P_ST_PKTNO, P_WB_PKTNO: pktno_q <= dat_i;
					P_ST_EOF: begin
						kind_q <= ctrl_pkg::RK_STATUS;
						len_q <= `CTRL_STATUS_LEN;
					end
					P_WB_TYPE: we_q <= dat_i[0];
					P_WB_EOF: begin
						kind_q <= ctrl_pkg::RK_WB;
						len_q <= cnt_q;
					end
					// Write reply holds one byte count
					P_WB_WEOF: begin
						kind_q <= ctrl_pkg::RK_WB;
						len_q <= 8'd1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		case (state_q)
			P_WB_LEN: cnt_q <= dat_i - `CTRL_WB_HDR_LEN;
			P_WB_ADRH: adr_q[15:8] <= dat_i;
			P_WB_ADRL: adr_q[7:0] <= dat_i;
			P_WB_COUNT: cnt_q <= dat_i;
			default: ;
		endcase
	end

	// Pops come from both the parser and the engine
	rd_not_empty: assert property (@(posedge clk_i) disable iff (reset_i)
		rd_o |-> !empty_i);

endmodule

`default_nettype wire

/* source/packet_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module packet_controller (
	input  wire logic                      clk_i,
	input  wire logic                      reset_i,
	input  wire logic [`CTRL_DAT_W-1:0]    dat_i,
	input  wire logic                      empty_i,
	output logic                           rd_o,
	output logic [`CTRL_DAT_W-1:0]         dat_o,
	output logic                           wr_o,
	input  wire logic                      full_i,
	output logic                           packet_o,
	input  wire logic [`CTRL_DAT_W-1:0]    d1_status_i,
	input  wire logic [`CTRL_DAT_W-1:0]    d2_status_i,
	input  wire logic [`CTRL_DAT_W-1:0]    d3_status_i,
	input  wire logic [`CTRL_DAT_W-1:0]    d4_status_i,
	input  wire logic                      status_change_i,
	output logic                           status_change_ack_o,
	output logic                           wb_cyc_o,
	output logic                           wb_stb_o,
	output logic                           wb_we_o,
	output logic [`CTRL_WB_ADR_W-1:0]      wb_adr_o,
	output logic [`CTRL_DAT_W-1:0]         wb_dat_o,
	input  wire logic [`CTRL_DAT_W-1:0]    wb_dat_i,
	input  wire logic                      wb_ack_i
);

	reply_if rp_if ();
	wb_cmd_if wc_if ();

	frame_parser u_parser (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.dat_i(dat_i),
		.empty_i(empty_i),
		.rd_o(rd_o),
		.status_change_i(status_change_i),
		.status_change_ack_o(status_change_ack_o),
		.rp(rp_if.parser),
		.wc(wc_if.parser)
	);

	wb_engine u_engine (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.full_i(full_i),
		.empty_i(empty_i),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_we_o(wb_we_o),
		.wb_adr_o(wb_adr_o),
		.wb_dat_o(wb_dat_o),
		.wb_dat_i(wb_dat_i),
		.wb_ack_i(wb_ack_i),
		.dat_i(dat_i),
		.wc(wc_if.engine)
	);

	reply_writer u_writer (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.full_i(full_i),
		.dat_o(dat_o),
		.wr_o(wr_o),
		.packet_o(packet_o),
		.d1_status_i(d1_status_i),
		.d2_status_i(d2_status_i),
		.d3_status_i(d3_status_i),
		.d4_status_i(d4_status_i),
		.rp(rp_if.writer),
		.wc(wc_if.writer)
	);

endmodule

`default_nettype wire

/* source/reply_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

interface reply_if;

	logic req;
	ctrl_pkg::reply_kind_e kind;
	logic [`CTRL_DAT_W-1:0] pktno;
	logic [`CTRL_DAT_W-1:0] len;
	logic [`CTRL_DAT_W-1:0] err;
	// Wishbone reply carries a byte count instead of read data
	logic wb_write;
	logic busy;

	modport parser (
		output req, kind, pktno, len, err, wb_write,
		input  busy
	);

	modport writer (
		input  req, kind, pktno, len, err, wb_write,
		output busy
	);

endinterface

`default_nettype wire

/* source/reply_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module reply_writer (
	input  wire logic                   clk_i,
	input  wire logic                   reset_i,
	input  wire logic                   full_i,
	output logic [`CTRL_DAT_W-1:0]      dat_o,
	output logic                        wr_o,
	output logic                        packet_o,
	input  wire logic [`CTRL_DAT_W-1:0] d1_status_i,
	input  wire logic [`CTRL_DAT_W-1:0] d2_status_i,
	input  wire logic [`CTRL_DAT_W-1:0] d3_status_i,
	input  wire logic [`CTRL_DAT_W-1:0] d4_status_i,
	reply_if.writer                     rp,
	wb_cmd_if.writer                    wc
);

	typedef enum logic [2:0] {W_IDLE, W_SOF, W_SRC, W_PKTNO, W_LEN, W_PAY, W_EOF} wstate_e;

	wstate_e state_q;
	logic [7:0] idx_q;
	logic rd_pay;
	logic pay_wr;
	logic [`CTRL_DAT_W-1:0] pay_dat;
	ctrl_pkg::src_id_e src;

	assign rd_pay = (rp.kind == ctrl_pkg::RK_WB) && !rp.wb_write;
	// Read payload paces itself on the engine
	assign pay_wr = rd_pay ? wc.rvalid : !full_i;
	assign wc.stream = (state_q == W_PAY) && rd_pay;
	assign rp.busy = (state_q != W_IDLE);
	assign packet_o = wr_o && (state_q == W_EOF);

	always_comb begin
		case (rp.kind)
			ctrl_pkg::RK_STATUS: src = ctrl_pkg::SRC_DBSTATUS;
			ctrl_pkg::RK_WB: src = ctrl_pkg::SRC_WISHBONE;
			default: src = ctrl_pkg::SRC_CONTROLLER;
		endcase
	end

	always_comb begin
		case (rp.kind)
			ctrl_pkg::RK_STATUS: begin
				case (idx_q[1:0])
					2'd0: pay_dat = d1_status_i;
					2'd1: pay_dat = d2_status_i;
					2'd2: pay_dat = d3_status_i;
					default: pay_dat = d4_status_i;
				endcase
			end
			ctrl_pkg::RK_WB: pay_dat = rp.wb_write ? wc.nbytes : wc.rdata;
			default: pay_dat = rp.err;
		endcase
	end

	always_comb begin
		wr_o = !full_i;
		dat_o = `CTRL_EOF;
		case (state_q)
			W_SOF: dat_o = `CTRL_SOF;
			W_SRC: dat_o = src;
			W_PKTNO: dat_o = rp.pktno;
			W_LEN: dat_o = rp.len;
			W_PAY: begin
				wr_o = pay_wr;
				dat_o = pay_dat;
			end
			W_EOF: dat_o = `CTRL_EOF;
			default: wr_o = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= W_IDLE;
		end else begin
			case (state_q)
				W_IDLE: if (rp.req) state_q <= W_SOF;
				W_SOF: if (!full_i) state_q <= W_SRC;
				W_SRC: if (!full_i) state_q <= W_PKTNO;
				W_PKTNO: if (!full_i) state_q <= W_LEN;
				W_LEN: if (!full_i) state_q <= (rp.len == 8'd0) ? W_EOF : W_PAY;
				W_PAY: if (pay_wr && idx_q == rp.len - 8'd1) state_q <= W_EOF;
				W_EOF: if (!full_i) state_q <= W_IDLE;
				default: state_q <= W_IDLE;
			endcase
		end
	end

	// Payload byte index
	always_ff @(posedge clk_i) begin
		if (state_q == W_LEN)
			idx_q <= 8'd0;
		else if (state_q == W_PAY && pay_wr)
			idx_q <= idx_q + 8'd1;
	end

	no_wr_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
		wr_o |-> !full_i);

endmodule

`default_nettype wire

/* source/wb_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

interface wb_cmd_if;

	// Job from the parser
	logic start;
	logic write;
	logic [`CTRL_WB_ADR_W-1:0] adr;
	logic [`CTRL_DAT_W-1:0] count;

	// Engine status and data
	logic done;
	logic [`CTRL_DAT_W-1:0] nbytes;
	logic take;
	logic [`CTRL_DAT_W-1:0] rdata;
	logic rvalid;

	// Writer is in the read payload
	logic stream;

	modport parser (output start, write, adr, count, input done, take);
	modport engine (
		input  start, write, adr, count, stream,
		output done, nbytes, take, rdata, rvalid
	);
	modport writer (input nbytes, rdata, rvalid, output stream);

endinterface

`default_nettype wire

/* source/wb_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module wb_engine (
	input  wire logic                      clk_i,
	input  wire logic                      reset_i,
	input  wire logic                      full_i,
	input  wire logic                      empty_i,
	output logic                           wb_cyc_o,
	output logic                           wb_stb_o,
	output logic                           wb_we_o,
	output logic [`CTRL_WB_ADR_W-1:0]      wb_adr_o,
	output logic [`CTRL_DAT_W-1:0]         wb_dat_o,
	input  wire logic [`CTRL_DAT_W-1:0]    wb_dat_i,
	input  wire logic                      wb_ack_i,
	input  wire logic [`CTRL_DAT_W-1:0]    dat_i,
	wb_cmd_if.engine                       wc
);

	logic cyc_q;
	logic stb_q;
	logic done_q;
	logic rfull_q;
	logic we_q;
	logic [`CTRL_WB_ADR_W-1:0] adr_q;
	logic [`CTRL_DAT_W-1:0] remain_q;
	logic [`CTRL_DAT_W-1:0] nbytes_q;
	logic [`CTRL_DAT_W-1:0] rbuf_q;
	logic ack_beat;
	logic read_ack;
	logic ready;

	assign ack_beat = cyc_q && stb_q && wb_ack_i;
	assign read_ack = ack_beat && !we_q;
	// A new beat starts only when its byte has somewhere to go
	assign ready = we_q ? !empty_i : (wc.stream && !full_i && !rfull_q);

	assign wb_cyc_o = cyc_q;
	assign wb_stb_o = stb_q;
	assign wb_we_o = cyc_q && we_q;
	assign wb_adr_o = adr_q;
	assign wb_dat_o = dat_i;

	assign wc.done = done_q;
	assign wc.nbytes = nbytes_q;
	assign wc.take = ack_beat && we_q;
	// Read byte that met a full output FIFO waits in rbuf_q
	assign wc.rvalid = !full_i && (rfull_q || read_ack);
	assign wc.rdata = rfull_q ? rbuf_q : wb_dat_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			cyc_q <= 1'b0;
			stb_q <= 1'b0;
			done_q <= 1'b0;
			rfull_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (wc.start) begin
				if (wc.count == '0)
					done_q <= 1'b1;
				else
					cyc_q <= 1'b1;
			end else if (cyc_q) begin
				if (ack_beat) begin
					stb_q <= 1'b0;
					if (remain_q == 8'd1) begin
						cyc_q <= 1'b0;
						done_q <= 1'b1;
					end
				end else if (!stb_q && ready) begin
					stb_q <= 1'b1;
				end
			end
			if (read_ack && full_i)
				rfull_q <= 1'b1;
			else if (rfull_q && !full_i)
				rfull_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (wc.start) begin
			adr_q <= wc.adr;
			remain_q <= wc.count;
			nbytes_q <= '0;
			we_q <= wc.write;
		end else if (ack_beat) begin
			adr_q <= adr_q + 1'b1;
			remain_q <= remain_q - 1'b1;
			nbytes_q <= nbytes_q + 1'b1;
		end
		if (read_ack && full_i)
			rbuf_q <= wb_dat_i;
	end

	stb_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
		wb_stb_o |-> wb_cyc_o);

endmodule

`default_nettype wire

/* verif/tb_models.sv */
`timescale 1ns/1ps
`default_nettype none

// Input byte FIFO, filled by the testbench and popped by the DUT
module in_fifo_model (
	input  wire logic       clk_i,
	input  wire logic       reset_i,
	input  wire logic       push_i,
	input  wire logic [7:0] push_dat_i,
	input  wire logic       pop_i,
	output logic [7:0]      dat_o,
	output logic            empty_o
);

	logic [7:0] mem [0:255];
	logic [7:0] wp_q;
	logic [7:0] rp_q;

	assign dat_o = mem[rp_q];
	assign empty_o = (wp_q == rp_q);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wp_q <= 8'd0;
			rp_q <= 8'd0;
		end else begin
			if (push_i) begin
				mem[wp_q] <= push_dat_i;
				wp_q <= wp_q + 8'd1;
			end
			if (pop_i && !empty_o)
				rp_q <= rp_q + 8'd1;
		end
	end

endmodule

// Output FIFO, each entry holds {packet_o, dat_o}
module out_fifo_model (
	input  wire logic       clk_i,
	input  wire logic       reset_i,
	input  wire logic       wr_i,
	input  wire logic [7:0] dat_i,
	input  wire logic       last_i,
	input  wire logic       pop_i,
	output logic [8:0]      entry_o,
	output logic            empty_o
);

	logic [8:0] mem [0:255];
	logic [7:0] wp_q;
	logic [7:0] rp_q;

	assign entry_o = mem[rp_q];
	assign empty_o = (wp_q == rp_q);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wp_q <= 8'd0;
			rp_q <= 8'd0;
		end else begin
			if (wr_i) begin
				mem[wp_q] <= {last_i, dat_i};
				wp_q <= wp_q + 8'd1;
			end
			if (pop_i && !empty_o)
				rp_q <= rp_q + 8'd1;
		end
	end

endmodule

// 256-byte Wishbone memory, ack one cycle after stb
module wb_mem_model (
	input  wire logic        clk_i,
	input  wire logic        reset_i,
	input  wire logic        cyc_i,
	input  wire logic        stb_i,
	input  wire logic        we_i,
	input  wire logic [15:0] adr_i,
	input  wire logic [7:0]  dat_i,
	output logic [7:0]       dat_o,
	output logic             ack_o
);

	logic [7:0] mem [0:255];

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = i[7:0] ^ 8'hC3;
	end

	assign dat_o = mem[adr_i[7:0]];

	always_ff @(posedge clk_i) begin
		if (reset_i)
			ack_o <= 1'b0;
		else
			ack_o <= cyc_i && stb_i && !ack_o;
		if (cyc_i && stb_i && ack_o && we_i)
			mem[adr_i[7:0]] <= dat_i;
	end

endmodule

`default_nettype wire

/* verif/tb_packet_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_params.svh"

module tb_packet_controller;

	localparam int EV_RESET = 0;
	localparam int EV_BCAST = 1;
	localparam int EV_REQ = 2;
	localparam int WAIT_LIMIT = 4000;

	logic clk_i;
	logic reset_i;
	logic [7:0] dat_i;
	logic empty_i;
	logic rd_o;
	logic [7:0] dat_o;
	logic wr_o;
	logic full_i;
	logic packet_o;
	logic [7:0] d1_status_i;
	logic [7:0] d2_status_i;
	logic [7:0] d3_status_i;
	logic [7:0] d4_status_i;
	logic status_change_i;
	logic status_change_ack_o;
	logic wb_cyc_o;
	logic wb_stb_o;
	logic wb_we_o;
	logic [15:0] wb_adr_o;
	logic [7:0] wb_dat_o;
	logic [7:0] wb_dat_i;
	logic wb_ack_i;

	logic in_push;
	logic [7:0] in_byte;
	logic out_pop;
	logic out_empty;
	logic [8:0] out_entry;

	logic [15:0] lfsr_q;
	logic [7:0] req_buf [0:63];
	logic [7:0] shadow [0:255];
	logic [7:0] wdata [0:7];
	logic [8:0] exp_q [$];
	logic [15:0] exp_wb_adr;
	logic exp_wb_we;
	int req_n;
	int ev;
	int pending;
	int errors;
	int checks;
	int replies;
	int acks;

	packet_controller dut0 (.*);

	in_fifo_model in0 (
		.clk_i(clk_i), .reset_i(reset_i), .push_i(in_push), .push_dat_i(in_byte),
		.pop_i(rd_o), .dat_o(dat_i), .empty_o(empty_i)
	);

	out_fifo_model out0 (
		.clk_i(clk_i), .reset_i(reset_i), .wr_i(wr_o), .dat_i(dat_o), .last_i(packet_o),
		.pop_i(out_pop), .entry_o(out_entry), .empty_o(out_empty)
	);

	wb_mem_model mem0 (
		.clk_i(clk_i), .reset_i(reset_i), .cyc_i(wb_cyc_o), .stb_i(wb_stb_o),
		.we_i(wb_we_o), .adr_i(wb_adr_o), .dat_i(wb_dat_o), .dat_o(wb_dat_i),
		.ack_o(wb_ack_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int k = 0; k < 8; k++) begin
			lfsr_q = lfsr_next(lfsr_q);
			b = {b[6:0], lfsr_q[0]};
		end
	endtask

	// Expected byte idx of the reply to the current event
	function automatic logic [7:0] reply_byte(input int idx);
		logic [7:0] src;
		logic [7:0] pkt;
		logic [7:0] len;
		logic [7:0] code;
		logic [7:0] pay;
		logic [7:0] a;
		logic [15:0] adr;
		int n;
		int kind;
		kind = 0;
		code = `CTRL_ERR_BAD_PACKET;
		pkt = 8'd0;
		n = 0;
		adr = 16'd0;
		if (ev == EV_RESET) begin
			code = `CTRL_ERR_RESET;
		end else if (ev == EV_BCAST) begin
			kind = 1;
		end else if (req_buf[0] != `CTRL_SOF) begin
			code = `CTRL_ERR_BAD_PACKET;
		end else if (req_buf[1] == `CTRL_DEST_STATUS) begin
			if (req_buf[3] == `CTRL_EOF) begin
				kind = 1;
				pkt = req_buf[2];
			end
		end else if (req_buf[1] == `CTRL_DEST_WB) begin
			adr = {req_buf[5], req_buf[6]};
			pkt = req_buf[2];
			if (req_buf[4][0]) begin
				n = req_buf[3] - `CTRL_WB_HDR_LEN;
				kind = (req_buf[n + 7] == `CTRL_EOF) ? 2 : 0;
			end else begin
				n = req_buf[7];
				kind = (req_buf[8] == `CTRL_EOF) ? 3 : 0;
			end
			if (kind == 0)
				pkt = 8'd0;
		end else begin
			code = `CTRL_ERR_BAD_DEST;
		end

		case (kind)
			1: begin
				src = ctrl_pkg::SRC_DBSTATUS;
				len = `CTRL_STATUS_LEN;
				case (idx)
					4: pay = d1_status_i;
					5: pay = d2_status_i;
					6: pay = d3_status_i;
					default: pay = d4_status_i;
				endcase
			end
			2: begin
				src = ctrl_pkg::SRC_WISHBONE;
				len = 8'd1;
				pay = n[7:0];
			end
			3: begin
				src = ctrl_pkg::SRC_WISHBONE;
				len = n[7:0];
				a = adr[7:0] + idx[7:0] - 8'd4;
				pay = shadow[a];
			end
			default: begin
				src = ctrl_pkg::SRC_CONTROLLER;
				len = 8'd1;
				pay = code;
			end
		endcase

		if (idx == 0)
			return `CTRL_SOF;
		if (idx == 1)
			return src;
		if (idx == 2)
			return pkt;
		if (idx == 3)
			return len;
		if (idx == len + 4)
			return `CTRL_EOF;
		return pay;
	endfunction

	task automatic expect_reply();
		int total;
		logic last;
		total = reply_byte(3) + 5;
		for (int i = 0; i < total; i++) begin
			last = (i == total - 1);
			exp_q.push_back({last, reply_byte(i)});
		end
		pending++;
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
		$display("checks=%0d errors=%0d replies=%0d", checks, errors, replies);
		$display("RESULT: FAIL");
		$finish;
	endtask

	task automatic add_byte(input logic [7:0] b);
		req_buf[req_n] = b;
		req_n++;
	endtask

	task automatic wait_replies();
		int t;
		t = 0;
		while (replies < pending && t < WAIT_LIMIT) begin
			@(posedge clk_i);
			t++;
		end
		if (replies < pending)
			stop_on_timeout("a reply");
	endtask

	task automatic wait_for_ack();
		int t;
		t = 0;
		while (status_change_ack_o !== 1'b1 && t < WAIT_LIMIT) begin
			@(posedge clk_i);
			t++;
		end
		if (status_change_ack_o !== 1'b1)
			stop_on_timeout("the status acknowledgment");
	endtask

	// Push the request one byte per cycle, then wait for its reply
	task automatic run_request();
		ev = EV_REQ;
		expect_reply();
		if (req_buf[1] == `CTRL_DEST_WB) begin
			exp_wb_adr = {req_buf[5], req_buf[6]};
			exp_wb_we = req_buf[4][0];
		end
		for (int i = 0; i < req_n; i++) begin
			@(posedge clk_i);
			in_push <= 1'b1;
			in_byte <= req_buf[i];
		end
		@(posedge clk_i);
		in_push <= 1'b0;
		wait_replies();
	endtask

	always @(posedge clk_i) begin
		lfsr_q = lfsr_next(lfsr_q);
		full_i <= lfsr_q[0];
	end

	always @(posedge clk_i) begin
		if (status_change_ack_o === 1'b1)
			acks++;
	end

	// Every acked beat uses the next address of the block
	always @(posedge clk_i) begin
		if (wb_cyc_o === 1'b1 && wb_stb_o === 1'b1 && wb_ack_i === 1'b1) begin
			check_value(wb_adr_o, exp_wb_adr, "Wishbone address");
			check_value(wb_we_o, exp_wb_we, "Wishbone write enable");
			exp_wb_adr = exp_wb_adr + 16'd1;
		end
	end

	// Drain the output FIFO, every other cycle at most
	initial begin
		out_pop = 1'b0;
		forever begin
			@(posedge clk_i);
			out_pop <= 1'b0;
			if (out_empty === 1'b0 && !out_pop) begin
				out_pop <= 1'b1;
				if (exp_q.size() == 0) begin
					errors++;
					$display("Output byte 0x%0h at %0t arrived with no reply pending",
						out_entry, $time);
				end else begin
					check_value(out_entry, exp_q.pop_front(), "reply {packet_o, byte}");
				end
				if (out_entry[8])
					replies++;
			end
		end
	end

	initial begin
		reset_i = 1'b1;
		full_i = 1'b0;
		in_push = 1'b0;
		in_byte = 8'd0;
		status_change_i = 1'b0;
		exp_wb_adr = 16'd0;
		exp_wb_we = 1'b0;
		errors = 0;
		checks = 0;
		replies = 0;
		acks = 0;
		pending = 0;
		lfsr_q = 16'd19807;
		random_byte(d1_status_i);
		random_byte(d2_status_i);
		random_byte(d3_status_i);
		random_byte(d4_status_i);
		for (int i = 0; i < 8; i++)
			random_byte(wdata[i]);
		for (int i = 0; i < 256; i++)
			shadow[i] = i[7:0] ^ 8'hC3;

		// Reset announcement
		ev = EV_RESET;
		expect_reply();
		repeat (8) @(posedge clk_i);
		reset_i <= 1'b0;
		wait_replies();

		req_n = 0;
		add_byte(`CTRL_SOF);
		add_byte(`CTRL_DEST_STATUS);
		add_byte(8'h21);
		add_byte(`CTRL_EOF);
		run_request();

		// Unsolicited broadcast
		ev = EV_BCAST;
		expect_reply();
		@(posedge clk_i);
		status_change_i <= 1'b1;
		wait_for_ack();
		status_change_i <= 1'b0;
		wait_replies();
		check_value(acks, 1, "acknowledgment pulses");

		// Block write of eight bytes at 0x..40
		req_n = 0;
		add_byte(`CTRL_SOF);
		add_byte(`CTRL_DEST_WB);
		add_byte(8'h33);
		add_byte(`CTRL_WB_HDR_LEN + 8'd8);
		add_byte(8'h01);
		add_byte(8'h7A);
		add_byte(8'h40);
		for (int i = 0; i < 8; i++) begin
			add_byte(wdata[i]);
			shadow[8'h40 + i] = wdata[i];
		end
		add_byte(`CTRL_EOF);
		run_request();
		for (int i = 8'h40; i < 8'h48; i++)
			check_value(mem0.mem[i], shadow[i], "memory byte");

		// Block read across the written region
		req_n = 0;
		add_byte(`CTRL_SOF);
		add_byte(`CTRL_DEST_WB);
		add_byte(8'h34);
		add_byte(8'd4);
		add_byte(8'h00);
		add_byte(8'h12);
		add_byte(8'h3C);
		add_byte(8'd12);
		add_byte(`CTRL_EOF);
		run_request();

		// Malformed requests
		req_n = 0;
		add_byte(8'h41);
		add_byte(`CTRL_DEST_STATUS);
		add_byte(8'h05);
		add_byte(`CTRL_EOF);
		run_request();

		req_n = 0;
		add_byte(`CTRL_SOF);
		add_byte(8'd0);
		add_byte(8'h07);
		add_byte(`CTRL_EOF);
		run_request();

		req_n = 0;
		add_byte(`CTRL_SOF);
		add_byte(8'd5);
		add_byte(8'h08);
		add_byte(`CTRL_EOF);
		run_request();

		req_n = 0;
		add_byte(`CTRL_SOF);
		add_byte(`CTRL_DEST_STATUS);
		add_byte(8'h09);
		add_byte(8'h55);
		run_request();

		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected reply bytes never arrived", exp_q.size());
		end
		$display("checks=%0d errors=%0d replies=%0d", checks, errors, replies);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/ctrl_pkg.sv
source/reply_if.sv
source/wb_cmd_if.sv
source/frame_parser.sv
source/wb_engine.sv
source/reply_writer.sv
source/packet_controller.sv
verif/tb_models.sv
verif/tb_packet_controller.sv
